//--- build.f
source/cpuPkg.sv
source/hazardIf.sv
source/controlUnit.sv
source/registerFile.sv
source/alu.sv
source/hazardUnit.sv
source/datapath.sv
source/cpuTop.sv
verif/cpuChecker.sv
verif/cpuTb.sv

//--- source/alu.sv
`default_nettype none

module alu (
    input  logic [cpuPkg::wordWidth-1:0] a,
    input  logic [cpuPkg::wordWidth-1:0] b,
    input  logic [3:0]                   opcode,
    input  logic [5:0]                   func,
    output logic [cpuPkg::wordWidth-1:0] result,
    output logic                         branchTaken
);
    localparam int msb = cpuPkg::wordWidth - 1;

    always_comb begin
        case (opcode)
            cpuPkg::opRtype: begin
                case (func)
                    cpuPkg::fnAdd: result = a + b;
                    cpuPkg::fnSub: result = a - b;
                    cpuPkg::fnAnd: result = a & b;
                    cpuPkg::fnOrr: result = a | b;
                    cpuPkg::fnNot: result = ~a;
                    cpuPkg::fnTcp: result = ~a + 1'b1;
                    cpuPkg::fnShl: result = a << 1;
                    // arithmetic shift, sign bit stays
                    cpuPkg::fnShr: result = {a[msb], a[msb:1]};
                    default: result = a;
                endcase
            end
            cpuPkg::opOri: result = a | b;
            cpuPkg::opLhi: result = b << 8;
            default: result = a + b;
        endcase
    end

    always_comb begin
        case (opcode)
            cpuPkg::opBne: branchTaken = (a != b);
            cpuPkg::opBeq: branchTaken = (a == b);
            // sign tests look at rs only
            cpuPkg::opBgz: branchTaken = !a[msb] && (a != '0);
            cpuPkg::opBlz: branchTaken = a[msb];
            default: branchTaken = 1'b0;
        endcase
    end
endmodule

`default_nettype wire

//--- source/controlUnit.sv
`default_nettype none

module controlUnit (
    input  cpuPkg::instrWord  instr,
    input  logic              bubble,
    output cpuPkg::ctrlBundle ctrl
);
    always_comb begin
        ctrl = '0;
        if (!bubble) begin
            case (instr.r.opcode)
                cpuPkg::opRtype: begin
                    case (instr.r.func)
                        cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOrr,
                        cpuPkg::fnNot, cpuPkg::fnTcp, cpuPkg::fnShl, cpuPkg::fnShr: begin
                            ctrl.regDst = 1'b1;
                            ctrl.isAlu = 1'b1;
                            ctrl.regWrite = 1'b1;
                        end
                        // alu passes rs through for the output port
                        cpuPkg::fnWwd: begin
                            ctrl.isAlu = 1'b1;
                            ctrl.isWwd = 1'b1;
                        end
                        cpuPkg::fnJpr: ctrl.isJumpReg = 1'b1;
                        cpuPkg::fnJrl: begin
                            ctrl.isJumpReg = 1'b1;
                            ctrl.regWrite = 1'b1;
                            ctrl.linkPc = 1'b1;
                        end
                        cpuPkg::fnHlt: ctrl.isHalt = 1'b1;
                        default: ctrl = '0;
                    endcase
                end
                cpuPkg::opAdi, cpuPkg::opOri, cpuPkg::opLhi: begin
                    ctrl.aluSrc = 1'b1;
                    ctrl.isAlu = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opLwd: begin
                    ctrl.memRead = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
                cpuPkg::opSwd: ctrl.memWrite = 1'b1;
                cpuPkg::opBne, cpuPkg::opBeq, cpuPkg::opBgz, cpuPkg::opBlz: begin
                    ctrl.isBranch = 1'b1;
                end
                cpuPkg::opJmp: ctrl.isJumpImm = 1'b1;
                cpuPkg::opJal: begin
                    ctrl.isJumpImm = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.linkPc = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end
endmodule

`default_nettype wire

//--- source/cpuPkg.sv
`default_nettype none

package cpuPkg;
    localparam int wordWidth = 16;

    // opcodes, bits 15:12 of every instruction
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opBgz = 4'd2;
    localparam logic [3:0] opBlz = 4'd3;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opOri = 4'd5;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opJal = 4'd10;
    localparam logic [3:0] opRtype = 4'd15;

    // R-type function field
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnNot = 6'd4;
    localparam logic [5:0] fnTcp = 6'd5;
    localparam logic [5:0] fnShl = 6'd6;
    localparam logic [5:0] fnShr = 6'd7;
    localparam logic [5:0] fnJpr = 6'd25;
    localparam logic [5:0] fnJrl = 6'd26;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } rFormat;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } iFormat;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target;
    } jFormat;

    typedef union packed {
        rFormat r;
        iFormat i;
        jFormat j;
    } instrWord;

    typedef struct packed {
        logic regDst;
        logic aluSrc;
        logic isAlu;
        logic isBranch;
        logic isJumpReg;
        logic isJumpImm;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic isWwd;
        logic isHalt;
        logic linkPc;
    } ctrlBundle;
endpackage

`default_nettype wire

//--- source/cpuTop.sv
`default_nettype none

module cpuTop #(
    parameter int regCount = 4
) (
    input  logic                         Clk,
    input  logic                         rst,
    output logic                         instrRead,
    output logic [cpuPkg::wordWidth-1:0] instrAddr,
    input  logic [cpuPkg::wordWidth-1:0] instrData,
    output logic                         dataRead,
    output logic                         dataWrite,
    output logic [cpuPkg::wordWidth-1:0] dataAddr,
    output logic [cpuPkg::wordWidth-1:0] dataWdata,
    input  logic [cpuPkg::wordWidth-1:0] dataRdata,
    output logic                         wwdValid,
    output logic [cpuPkg::wordWidth-1:0] outputPort,
    output logic                         halted,
    output logic [cpuPkg::wordWidth-1:0] numInst
);
    localparam int regBits = $clog2(regCount);

    cpuPkg::instrWord             dcInstr;
    logic                         dcBubble;
    cpuPkg::ctrlBundle            dcCtrl;
    logic [regBits-1:0]           rfRs;
    logic [regBits-1:0]           rfRt;
    logic [regBits-1:0]           rfRd;
    logic [cpuPkg::wordWidth-1:0] rfWdata;
    logic                         rfWe;
    logic [cpuPkg::wordWidth-1:0] rfData1;
    logic [cpuPkg::wordWidth-1:0] rfData2;
    logic [cpuPkg::wordWidth-1:0] aluA;
    logic [cpuPkg::wordWidth-1:0] aluB;
    logic [3:0]                   aluOpcode;
    logic [5:0]                   aluFunc;
    logic [cpuPkg::wordWidth-1:0] aluResult;
    logic                         branchTaken;

    hazardIf #(.regCount(regCount)) hz0 ();

    datapath #(.regCount(regCount)) datapath0 (
        .Clk        (Clk),
        .rst        (rst),
        .instrRead  (instrRead),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataRdata  (dataRdata),
        .hz         (hz0.datapath),
        .dcInstr    (dcInstr),
        .dcBubble   (dcBubble),
        .dcCtrl     (dcCtrl),
        .rfRs       (rfRs),
        .rfRt       (rfRt),
        .rfRd       (rfRd),
        .rfWdata    (rfWdata),
        .rfWe       (rfWe),
        .rfData1    (rfData1),
        .rfData2    (rfData2),
        .aluA       (aluA),
        .aluB       (aluB),
        .aluOpcode  (aluOpcode),
        .aluFunc    (aluFunc),
        .aluResult  (aluResult),
        .branchTaken(branchTaken),
        .wwdValid   (wwdValid),
        .outputPort (outputPort),
        .halted     (halted),
        .numInst    (numInst)
    );

    controlUnit control0 (
        .instr (dcInstr),
        .bubble(dcBubble),
        .ctrl  (dcCtrl)
    );

    registerFile #(.regCount(regCount)) regFile0 (
        .Clk   (Clk),
        .rst   (rst),
        .rs    (rfRs),
        .rt    (rfRt),
        .rd    (rfRd),
        .wdata (rfWdata),
        .we    (rfWe),
        .rdata1(rfData1),
        .rdata2(rfData2)
    );

    alu alu0 (
        .a          (aluA),
        .b          (aluB),
        .opcode     (aluOpcode),
        .func       (aluFunc),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    hazardUnit hazard0 (
        .hz(hz0.hazard)
    );
endmodule

`default_nettype wire

//--- source/datapath.sv
`default_nettype none

module datapath #(
    parameter  int regCount = 4,
    localparam int regBits = $clog2(regCount)
) (
    input  logic                         Clk,
    input  logic                         rst,
    output logic                         instrRead,
    output logic [cpuPkg::wordWidth-1:0] instrAddr,
    input  logic [cpuPkg::wordWidth-1:0] instrData,
    output logic                         dataRead,
    output logic                         dataWrite,
    output logic [cpuPkg::wordWidth-1:0] dataAddr,
    output logic [cpuPkg::wordWidth-1:0] dataWdata,
    input  logic [cpuPkg::wordWidth-1:0] dataRdata,
    hazardIf.datapath                    hz,
    output cpuPkg::instrWord             dcInstr,
    output logic                         dcBubble,
    input  cpuPkg::ctrlBundle            dcCtrl,
    output logic [regBits-1:0]           rfRs,
    output logic [regBits-1:0]           rfRt,
    output logic [regBits-1:0]           rfRd,
    output logic [cpuPkg::wordWidth-1:0] rfWdata,
    output logic                         rfWe,
    input  logic [cpuPkg::wordWidth-1:0] rfData1,
    input  logic [cpuPkg::wordWidth-1:0] rfData2,
    output logic [cpuPkg::wordWidth-1:0] aluA,
    output logic [cpuPkg::wordWidth-1:0] aluB,
    output logic [3:0]                   aluOpcode,
    output logic [5:0]                   aluFunc,
    input  logic [cpuPkg::wordWidth-1:0] aluResult,
    input  logic                         branchTaken,
    output logic                         wwdValid,
    output logic [cpuPkg::wordWidth-1:0] outputPort,
    output logic                         halted,
    output logic [cpuPkg::wordWidth-1:0] numInst
);
    localparam int w = cpuPkg::wordWidth;

    logic         running;
    logic [w-1:0] pc;
    logic [w-1:0] pcPlus1;
    logic [w-1:0] nextPc;

    cpuPkg::instrWord ifIdInstr;
    logic [w-1:0]     ifIdPc1;
    logic             ifIdBubble;

    cpuPkg::instrWord  idExInstr;
    cpuPkg::ctrlBundle idExCtrl;
    logic [w-1:0]      idExPc1;
    logic [w-1:0]      idExA;
    logic [w-1:0]      idExB;
    logic [w-1:0]      idExImm;
    logic [regBits-1:0] idExDst;
    logic              idExBubble;

    cpuPkg::ctrlBundle exMemCtrl;
    logic [w-1:0]      exMemResult;
    logic [w-1:0]      exMemStore;
    logic [regBits-1:0] exMemDst;
    logic              exMemBubble;

    cpuPkg::ctrlBundle memWbCtrl;
    logic [w-1:0]      memWbResult;
    logic [w-1:0]      memWbLoad;
    logic [regBits-1:0] memWbDst;
    logic              memWbBubble;

    logic [w-1:0]       dcImm;
    logic [w-1:0]       dcJumpTarget;
    logic [regBits-1:0] dcDst;
    logic [w-1:0]       opA;
    logic [w-1:0]       opB;
    logic [w-1:0]       exResult;
    logic [w-1:0]       exTarget;
    logic               exRedirect;
    logic [w-1:0]       wbData;
    logic               wbRetire;
    logic               haltNow;

    // decode
    assign dcInstr = ifIdInstr;
    assign dcBubble = ifIdBubble;
    assign rfRs = regBits'(ifIdInstr.r.rs);
    assign rfRt = regBits'(ifIdInstr.r.rt);
    assign dcDst = dcCtrl.linkPc ? regBits'(2) :
                   dcCtrl.regDst ? regBits'(ifIdInstr.r.rd) : rfRt;
    // or-immediate is the one zero-extended immediate
    assign dcImm = (ifIdInstr.i.opcode == cpuPkg::opOri) ?
                   {{(w - 8){1'b0}}, ifIdInstr.i.imm} :
                   {{(w - 8){ifIdInstr.i.imm[7]}}, ifIdInstr.i.imm};
    assign dcJumpTarget = {ifIdPc1[w-1:12], ifIdInstr.j.target};

    assign hz.dcRs = rfRs;
    assign hz.dcRt = rfRt;
    assign hz.useRs = !ifIdBubble &&
        !(ifIdInstr.r.opcode inside {cpuPkg::opJmp, cpuPkg::opJal, cpuPkg::opLhi});
    assign hz.useRt = !ifIdBubble &&
        ((ifIdInstr.r.opcode == cpuPkg::opRtype &&
          ifIdInstr.r.func inside {cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOrr}) ||
         ifIdInstr.r.opcode inside {cpuPkg::opBne, cpuPkg::opBeq, cpuPkg::opSwd});

    // execute
    always_comb begin
        case (hz.forwardA)
            2'b01: opA = exMemResult;
            2'b10: opA = wbData;
            default: opA = idExA;
        endcase
        case (hz.forwardB)
            2'b01: opB = exMemResult;
            2'b10: opB = wbData;
            default: opB = idExB;
        endcase
    end

    assign aluA = opA;
    assign aluB = idExCtrl.aluSrc ? idExImm : opB;
    assign aluOpcode = idExInstr.r.opcode;
    assign aluFunc = idExInstr.r.func;
    // non-alu results are either the link value or a memory address
    assign exResult = idExCtrl.isAlu ? aluResult :
                      idExCtrl.linkPc ? idExPc1 : opA + idExImm;
    assign exRedirect = !idExBubble &&
                        ((idExCtrl.isBranch && branchTaken) || idExCtrl.isJumpReg);
    assign exTarget = idExCtrl.isBranch ? idExPc1 + idExImm : opA;

    assign hz.exRs = regBits'(idExInstr.r.rs);
    assign hz.exRt = regBits'(idExInstr.r.rt);
    assign hz.exDst = idExDst;
    assign hz.exMemRead = !idExBubble && idExCtrl.memRead;
    assign hz.memDst = exMemDst;
    assign hz.memRegWrite = !exMemBubble && exMemCtrl.regWrite;
    assign hz.wbDst = memWbDst;
    assign hz.wbRegWrite = rfWe;

    // writeback
    assign wbData = memWbCtrl.memToReg ? memWbLoad : memWbResult;
    assign wbRetire = !memWbBubble;
    assign haltNow = wbRetire && memWbCtrl.isHalt;
    assign rfRd = memWbDst;
    assign rfWdata = wbData;
    assign rfWe = wbRetire && memWbCtrl.regWrite;

    assign instrRead = running;
    assign instrAddr = pc;
    assign dataRead = !exMemBubble && exMemCtrl.memRead;
    // a store behind the retiring halt must not land
    assign dataWrite = !exMemBubble && exMemCtrl.memWrite && !haltNow;
    assign dataAddr = exMemResult;
    assign dataWdata = exMemStore;

    assign pcPlus1 = pc + 1'b1;

    always_comb begin
        if (hz.loadStall) begin
            nextPc = pc;
        end else if (exRedirect) begin
            nextPc = exTarget;
        end else if (dcCtrl.isJumpImm) begin
            nextPc = dcJumpTarget;
        end else begin
            nextPc = pcPlus1;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            running <= 1'b0;
            halted <= 1'b0;
            pc <= '0;
            ifIdBubble <= 1'b1;
            idExBubble <= 1'b1;
            exMemBubble <= 1'b1;
            memWbBubble <= 1'b1;
            numInst <= '0;
            wwdValid <= 1'b0;
        end else begin
            running <= !(halted || haltNow);
            if (running) begin
                pc <= nextPc;
            end
            if (!hz.loadStall) begin
                ifIdBubble <= !running || exRedirect || dcCtrl.isJumpImm;
            end
            idExBubble <= ifIdBubble || exRedirect || hz.loadStall;
            exMemBubble <= idExBubble;
            memWbBubble <= exMemBubble;
            // everything younger than the halt is dropped
            if (haltNow) begin
                halted <= 1'b1;
                ifIdBubble <= 1'b1;
                idExBubble <= 1'b1;
                exMemBubble <= 1'b1;
                memWbBubble <= 1'b1;
            end
            if (wbRetire) begin
                numInst <= numInst + 1'b1;
            end
            wwdValid <= wbRetire && memWbCtrl.isWwd;
        end
    end

    always_ff @(posedge Clk) begin
        if (!hz.loadStall) begin
            ifIdInstr <= instrData;
            ifIdPc1 <= pcPlus1;
        end
        idExInstr <= ifIdInstr;
        idExCtrl <= dcCtrl;
        idExPc1 <= ifIdPc1;
        idExA <= rfData1;
        idExB <= rfData2;
        idExImm <= dcImm;
        idExDst <= dcDst;
        exMemCtrl <= idExCtrl;
        exMemResult <= exResult;
        exMemStore <= opB;
        exMemDst <= idExDst;
        memWbCtrl <= exMemCtrl;
        memWbResult <= exMemResult;
        memWbLoad <= dataRdata;
        memWbDst <= exMemDst;
        if (wbRetire && memWbCtrl.isWwd) begin
            outputPort <= memWbResult;
        end
    end
endmodule

`default_nettype wire

//--- source/hazardIf.sv
`default_nettype none

interface hazardIf #(
    parameter int regCount = 4
);
    localparam int regBits = $clog2(regCount);

    // decode-stage sources
    logic [regBits-1:0] dcRs;
    logic [regBits-1:0] dcRt;
    logic               useRs;
    logic               useRt;
    // producers further down the pipe
    logic [regBits-1:0] exRs;
    logic [regBits-1:0] exRt;
    logic [regBits-1:0] exDst;
    logic               exMemRead;
    logic [regBits-1:0] memDst;
    logic               memRegWrite;
    logic [regBits-1:0] wbDst;
    logic               wbRegWrite;
    // 01 takes the memory stage, 10 takes writeback
    logic [1:0]         forwardA;
    logic [1:0]         forwardB;
    logic               loadStall;

    modport datapath (
        output dcRs, dcRt, useRs, useRt, exRs, exRt, exDst, exMemRead,
        output memDst, memRegWrite, wbDst, wbRegWrite,
        input  forwardA, forwardB, loadStall
    );

    modport hazard (
        input  dcRs, dcRt, useRs, useRt, exRs, exRt, exDst, exMemRead,
        input  memDst, memRegWrite, wbDst, wbRegWrite,
        output forwardA, forwardB, loadStall
    );
endinterface

`default_nettype wire

//--- source/hazardUnit.sv
`default_nettype none

module hazardUnit (
    hazardIf.hazard hz
);
    // the younger producer in the memory stage wins over writeback
    function automatic logic [1:0] pickForward(input logic memHit, input logic wbHit);
        if (memHit) begin
            return 2'b01;
        end
        if (wbHit) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    assign hz.forwardA = pickForward(hz.memRegWrite && hz.memDst == hz.exRs,
                                     hz.wbRegWrite && hz.wbDst == hz.exRs);
    assign hz.forwardB = pickForward(hz.memRegWrite && hz.memDst == hz.exRt,
                                     hz.wbRegWrite && hz.wbDst == hz.exRt);

    // load data only exists after the memory stage, one bubble covers it
    assign hz.loadStall = hz.exMemRead &&
                          ((hz.useRs && hz.dcRs == hz.exDst) ||
                           (hz.useRt && hz.dcRt == hz.exDst));
endmodule

`default_nettype wire

//--- source/registerFile.sv
`default_nettype none

module registerFile #(
    parameter  int regCount = 4,
    localparam int regBits = $clog2(regCount)
) (
    input  logic                         Clk,
    input  logic                         rst,
    input  logic [regBits-1:0]           rs,
    input  logic [regBits-1:0]           rt,
    input  logic [regBits-1:0]           rd,
    input  logic [cpuPkg::wordWidth-1:0] wdata,
    input  logic                         we,
    output logic [cpuPkg::wordWidth-1:0] rdata1,
    output logic [cpuPkg::wordWidth-1:0] rdata2
);
    logic [cpuPkg::wordWidth-1:0] regs [regCount];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // writeback and decode share a cycle, so bypass the write
    assign rdata1 = (we && rd == rs) ? wdata : regs[rs];
    assign rdata2 = (we && rd == rt) ? wdata : regs[rt];
endmodule

`default_nettype wire

//--- verif/cpuChecker.sv
`default_nettype none

module cpuChecker (
    input logic                         Clk,
    input logic                         rst,
    input logic                         instrRead,
    input logic                         wwdValid,
    input logic [cpuPkg::wordWidth-1:0] outputPort,
    input logic                         halted,
    input logic [cpuPkg::wordWidth-1:0] numInst
);
    timeunit 1ns;
    timeprecision 1ps;

    string                        testName = "none";
    logic [cpuPkg::wordWidth-1:0] pending [$];
    logic                         active = 1'b0;
    logic                         sawHalt = 1'b0;
    int                           valueErrors = 0;
    int                           protocolErrors = 0;

    // called right after reset is released
    task automatic beginTest(input string name);
        testName = name;
        pending.delete();
        sawHalt = 1'b0;
        active = 1'b1;
        if (numInst !== '0) begin
            $display("Error in %s: retired count after reset expected 0, actual %0d",
                     name, numInst);
            valueErrors++;
        end
        if (halted !== 1'b0) begin
            $display("test %s: halted is still high after reset", name);
            protocolErrors++;
        end
    endtask

    task automatic expectOutput(input logic [cpuPkg::wordWidth-1:0] value);
        pending.push_back(value);
    endtask

    task automatic endTest(input int retired);
        if (pending.size() != 0) begin
            $display("test %s: %0d expected output strobes never came",
                     testName, pending.size());
            protocolErrors++;
        end
        if (numInst !== cpuPkg::wordWidth'(retired)) begin
            $display("Error in %s: retired count expected %0d, actual %0d",
                     testName, retired, numInst);
            valueErrors++;
        end
        active = 1'b0;
    endtask

    task automatic checkStrobe();
        logic [cpuPkg::wordWidth-1:0] want;
        if (pending.size() == 0) begin
            $display("test %s: extra output strobe with value 0x%h", testName, outputPort);
            protocolErrors++;
        end else begin
            want = pending.pop_front();
            if (outputPort !== want) begin
                $display("Error in %s: output port expected 0x%h, actual 0x%h",
                         testName, want, outputPort);
                valueErrors++;
            end
        end
    endtask

    // outputs change on the rising edge, so look at them in the middle of the cycle
    always @(negedge Clk) begin
        if (rst) begin
            sawHalt = 1'b0;
        end else if (active) begin
            if (wwdValid === 1'b1) begin
                checkStrobe();
            end
            if (sawHalt && halted !== 1'b1) begin
                $display("test %s: halted dropped after it had risen", testName);
                protocolErrors++;
                sawHalt = 1'b0;
            end
            if (halted === 1'b1) begin
                sawHalt = 1'b1;
                if (instrRead !== 1'b0) begin
                    $display("test %s: instruction fetch still active while halted", testName);
                    protocolErrors++;
                end
            end
        end
    end
endmodule

`default_nettype wire

//--- verif/cpuTb.sv
`default_nettype none

module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numTests = 7;
    localparam int maxWords = 16;
    localparam int maxOutputs = 8;
    localparam int w = cpuPkg::wordWidth;

    logic         Clk;
    logic         rst;
    logic         instrRead;
    logic [w-1:0] instrAddr;
    logic [w-1:0] instrData;
    logic         dataRead;
    logic         dataWrite;
    logic [w-1:0] dataAddr;
    logic [w-1:0] dataWdata;
    logic [w-1:0] dataRdata;
    logic         wwdValid;
    logic [w-1:0] outputPort;
    logic         halted;
    logic [w-1:0] numInst;

    logic [w-1:0] imem [256];
    logic [w-1:0] dmem [256];
    int           cycleCount;
    int           cycleLimit;
    int           current = 0;

    // one entry per test with its name, hand-assembled program, output port values and retired count
    string names [numTests] = '{"arith", "logic", "loadStore", "branchEq",
                                "branchSign", "jumps", "reset"};
    logic [w-1:0] programs [numTests][maxWords] = '{
        '{16'h6112, 16'h5534, 16'h42FD, 16'hF6C0, 16'hFC1C, 16'hF6C1, 16'hFC1C, 16'hF8C5,
          16'hFC1C, 16'h4F7F, 16'hFC1C, 16'hF41C, 16'hF01D, 16'h0000, 16'h0000, 16'h0000},
        '{16'h415A, 16'h62A5, 16'h5AF0, 16'hF6C2, 16'hFC1C, 16'hF6C3, 16'hFC1C, 16'hFCC4,
          16'hFC1C, 16'hF8C6, 16'hFC1C, 16'hF8C7, 16'hFC1C, 16'hF01D, 16'h0000, 16'h0000},
        '{16'h4120, 16'h627E, 16'h5A11, 16'h8603, 16'h7703, 16'hFC1C, 16'h8500, 16'h7600,
          16'hF6C0, 16'hFC1C, 16'hF01D, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h4105, 16'h42FE, 16'h4305, 16'h1601, 16'hF41C, 16'h1702, 16'hF01C, 16'hF01C,
          16'h0701, 16'hF81C, 16'h0602, 16'hF01C, 16'hF01C, 16'hFC1C, 16'hF01D, 16'h0000},
        '{16'h4105, 16'h42FE, 16'h2801, 16'hF41C, 16'h2402, 16'hF01C, 16'hF01C, 16'h3401,
          16'hF81C, 16'h3802, 16'hF01C, 16'hF01C, 16'h2001, 16'hF41C, 16'hF01D, 16'h0000},
        '{16'h9002, 16'hF01C, 16'hA004, 16'hF01C, 16'hF81C, 16'h4109, 16'hF419, 16'hF01C,
          16'hF01C, 16'h430D, 16'hFC1A, 16'hF01C, 16'hF01C, 16'hF81C, 16'hF01D, 16'h0000},
        '{16'hF41C, 16'hF81C, 16'hFC1C, 16'hF01D, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
    };
    int programLen [numTests] = '{13, 14, 11, 15, 15, 15, 4};
    logic [w-1:0] outputs [numTests][maxOutputs] = '{
        '{16'h1231, 16'h1237, 16'h0003, 16'h0082, 16'h1234, 16'h0, 16'h0, 16'h0},
        '{16'h0050, 16'hA5FA, 16'h5A05, 16'h4BE0, 16'hD2F8, 16'h0, 16'h0, 16'h0},
        '{16'h7E11, 16'h0040, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
        '{16'h0005, 16'hFFFE, 16'h0005, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
        '{16'h0005, 16'hFFFE, 16'h0005, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
        '{16'h0003, 16'h000B, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0},
        '{16'h0000, 16'h0000, 16'h0000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0}
    };
    int outputCount [numTests] = '{5, 5, 2, 3, 3, 2, 3};
    int retired [numTests] = '{13, 14, 11, 11, 11, 9, 4};

    cpuTop dut0 (
        .Clk       (Clk),
        .rst       (rst),
        .instrRead (instrRead),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataRdata (dataRdata),
        .wwdValid  (wwdValid),
        .outputPort(outputPort),
        .halted    (halted),
        .numInst   (numInst)
    );

    cpuChecker checker0 (
        .Clk       (Clk),
        .rst       (rst),
        .instrRead (instrRead),
        .wwdValid  (wwdValid),
        .outputPort(outputPort),
        .halted    (halted),
        .numInst   (numInst)
    );

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;

    // both memories answer combinationally and data only comes back on a read strobe
    assign instrData = imem[instrAddr[7:0]];
    assign dataRdata = (dataRead === 1'b1) ? dmem[dataAddr[7:0]] : 'x;

    // data writes land on the edge
    always @(posedge Clk) begin
        if (dataWrite === 1'b1) begin
            dmem[dataAddr[7:0]] <= dataWdata;
        end
    end

    task automatic runTest(input int t);
        rst = 1'b1;
        for (int a = 0; a < 256; a++) begin
            imem[a] = (a < programLen[t]) ? programs[t][a] : '0;
            dmem[a] = '0;
        end
        repeat (5) @(posedge Clk);
        #2;
        rst = 1'b0;
        checker0.beginTest(names[t]);
        for (int i = 0; i < outputCount[t]; i++) begin
            checker0.expectOutput(outputs[t][i]);
        end
        while (halted !== 1'b1) begin
            @(posedge Clk);
            #2;
        end
        // a few more cycles to see that the core stays halted and quiet
        repeat (4) @(posedge Clk);
        #2;
        checker0.endTest(retired[t]);
    endtask

    initial begin
        for (int t = 0; t < numTests; t++) begin
            current = t;
            runTest(t);
        end
        $display("run complete: %0d value errors, %0d strobe or halt errors",
                 checker0.valueErrors, checker0.protocolErrors);
        if (checker0.valueErrors + checker0.protocolErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        cycleLimit = 0;
        for (int t = 0; t < numTests; t++) begin
            cycleLimit += 8 * programLen[t] + 50;
        end
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("timeout: test %s did not halt within the budget of %0d cycles",
                 names[current], cycleLimit);
        $display("*** FAILED ***");
        $finish;
    end
endmodule

`default_nettype wire
